//--- source/fdc_pkg.sv
// shared fdc types; sectors are fixed at 512 bytes and map to one storage block each
package fdc_pkg;

	// ==============================
	// host registers
	// ==============================
	typedef logic [1:0] reg_addr_t;

	localparam reg_addr_t A_STATUS  = 2'd0; // read side of address 0
	localparam reg_addr_t A_COMMAND = 2'd0; // write side of address 0
	localparam reg_addr_t A_TRACK   = 2'd1;
	localparam reg_addr_t A_SECTOR  = 2'd2;
	localparam reg_addr_t A_DATA    = 2'd3;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  track_t;
	typedef logic [7:0]  sector_t;
	typedef logic [8:0]  buf_addr_t;
	typedef logic [31:0] lba_t;

	localparam int SECTOR_BYTES = 512;

	// command opcodes, upper nibble; bit 0 of step/read/write is the update or multi flag
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_STEP      = 4'h2;
	localparam logic [3:0] CMD_STEP_IN   = 4'h4;
	localparam logic [3:0] CMD_STEP_OUT  = 4'h6;
	localparam logic [3:0] CMD_READ      = 4'h8;
	localparam logic [3:0] CMD_WRITE     = 4'hA;
	localparam logic [3:0] CMD_FORCE_INT = 4'hD;

	// ==============================
	// internal buses
	// ==============================
	typedef struct packed {
		logic      wr_pulse; // rising wr seen
		logic      rd_done;  // falling rd seen
		reg_addr_t addr;
		byte_t     data;
	} host_event_t;

	typedef struct packed {
		logic    start_read;
		logic    start_write;
		track_t  track;
		logic    side;
		sector_t sector;
	} block_req_t;

	typedef struct packed {
		buf_addr_t addr;
		byte_t     wdata;
		logic      we;
	} buf_port_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SETTLE,
		ST_SEARCH,
		ST_FETCH,
		ST_XFER_WAIT,
		ST_XFER,
		ST_FLUSH,
		ST_END
	} engine_state_t;

endpackage

//--- source/fdc_host_port.sv
// host strobes are levels sampled on clk_sys; events come one cycle after the edge
`timescale 1ns/10ps

module fdc_host_port (
	input  logic                 clk_sys,
	input  logic                 reset_spin,
	input  logic                 rd,
	input  logic                 wr,
	input  fdc_pkg::reg_addr_t   addr,
	input  fdc_pkg::byte_t       din,
	output fdc_pkg::host_event_t host_event
);
	import fdc_pkg::*;

	logic      rd_q;
	logic      wr_q;
	reg_addr_t rd_addr; // address held across the read cycle

	always_ff @(posedge clk_sys) begin
		// payload, follows the strobe edges
		if (rd && !rd_q)
			rd_addr <= addr;
		if (wr && !wr_q) begin
			host_event.addr <= addr;
			host_event.data <= din;
		end else if (rd_q && !rd) begin
			host_event.addr <= rd_addr;
		end

		if (reset_spin) begin
			rd_q                <= 1'b0;
			wr_q                <= 1'b0;
			host_event.wr_pulse <= 1'b0;
			host_event.rd_done  <= 1'b0;
		end else begin
			rd_q                <= rd;
			wr_q                <= wr;
			host_event.wr_pulse <= wr && !wr_q;
			host_event.rd_done  <= rd_q && !rd && !(wr && !wr_q); // write edge wins
		end
	end

endmodule

//--- source/fdc_command_engine.sv
// wd1793-style command engine; no lost-data timeout, a host that ignores drq stalls the command
`timescale 1ns/10ps

module fdc_command_engine #(
	parameter int SECTORS_PER_TRACK = 9,
	parameter int SETTLE_CYCLES     = 64
) (
	input  logic                 clk_sys,
	input  logic                 reset_spin,
	input  fdc_pkg::host_event_t host_event,
	input  fdc_pkg::reg_addr_t   addr,
	input  logic                 ready,
	input  logic                 wp,
	input  logic                 side,
	input  logic                 index,
	input  logic                 block_done,
	input  fdc_pkg::byte_t       buf_rdata,
	output fdc_pkg::byte_t       dout,
	output logic                 drq,
	output logic                 busy,
	output logic                 intrq,
	output fdc_pkg::block_req_t  req,
	output fdc_pkg::buf_port_t   buf_port
);
	import fdc_pkg::*;

	localparam int CW = $clog2(SETTLE_CYCLES + 1);

	engine_state_t state;
	track_t        track_reg;
	track_t        head;      // real head position
	track_t        next_head;
	sector_t       sector_reg;
	byte_t         data_reg;
	byte_t         status;
	buf_addr_t     byte_addr;
	logic [CW-1:0] settle_cnt;
	logic [3:0]    op;
	logic          step_dir;  // 1 = out, towards track 0
	logic          step_out;
	logic          multi;
	logic          is_write;
	logic          type2;     // status register shows type II bits
	logic          head_loaded;
	logic          not_found;
	logic          wr_fault;
	logic          start_rd;
	logic          start_wr;
	logic          buf_we;
	logic          cmd_ev;
	logic          rd_data_ev;
	logic          wr_data_ev;
	logic          last_byte;
	logic          bad_sector;

	assign op         = host_event.data[7:4];
	assign cmd_ev     = host_event.wr_pulse && (host_event.addr == A_COMMAND);
	assign wr_data_ev = host_event.wr_pulse && (host_event.addr == A_DATA);
	assign rd_data_ev = host_event.rd_done && (host_event.addr == A_DATA);
	assign last_byte  = byte_addr == buf_addr_t'(SECTOR_BYTES - 1);
	assign bad_sector = (sector_reg == '0) || (sector_reg > sector_t'(SECTORS_PER_TRACK));

	// step direction from the command if given, else the last one
	assign step_out  = host_event.data[6] ? host_event.data[5] : step_dir;
	assign next_head = step_out ? ((head == '0) ? head : head - 1'b1) : head + 1'b1; // stops at 0

	assign status = {
		~ready,
		wp & is_write,
		type2 ? wr_fault : head_loaded,
		not_found,
		1'b0,
		type2 ? 1'b0 : (head == '0),
		type2 ? drq : index,
		busy
	};

	always_comb begin
		case (addr)
			A_STATUS: dout = status;
			A_TRACK:  dout = track_reg;
			A_SECTOR: dout = sector_reg;
			default:  dout = (state == ST_XFER && !is_write) ? buf_rdata : data_reg;
		endcase
	end

	assign req      = '{start_read: start_rd, start_write: start_wr, track: head,
			side: side, sector: sector_reg};
	assign buf_port = '{addr: byte_addr, wdata: data_reg, we: buf_we};

	always_ff @(posedge clk_sys) begin
		if (host_event.wr_pulse && host_event.addr == A_DATA)
			data_reg <= host_event.data;

		if (reset_spin) begin
			state       <= ST_IDLE;
			track_reg   <= '0;
			sector_reg  <= '0;
			head        <= '0;
			byte_addr   <= '0;
			settle_cnt  <= '0;
			step_dir    <= 1'b0;
			multi       <= 1'b0;
			is_write    <= 1'b0;
			type2       <= 1'b0;
			head_loaded <= 1'b0;
			not_found   <= 1'b0;
			wr_fault    <= 1'b0;
			busy        <= 1'b0;
			drq         <= 1'b0;
			intrq       <= 1'b0;
			start_rd    <= 1'b0;
			start_wr    <= 1'b0;
			buf_we      <= 1'b0;
		end else begin
			start_rd <= 1'b0;
			start_wr <= 1'b0;

			// ==============================
			// command sequencing
			// ==============================
			case (state)
				ST_SETTLE:
					if (settle_cnt == '0)
						state <= type2 ? ST_SEARCH : ST_END;
					else
						settle_cnt <= settle_cnt - 1'b1;
				ST_SEARCH:
					if (!ready || bad_sector) begin
						not_found <= 1'b1; // record not found
						state     <= ST_END;
					end else if (is_write) begin
						byte_addr <= '0;
						drq       <= 1'b1;
						state     <= ST_XFER;
					end else begin
						start_rd <= 1'b1;
						state    <= ST_FETCH;
					end
				ST_FETCH:
					if (block_done) begin
						byte_addr <= '0;
						state     <= ST_XFER_WAIT;
					end
				ST_XFER_WAIT:
					if (!is_write) begin
						drq   <= 1'b1; // buffer data valid next cycle
						state <= ST_XFER;
					end else begin
						buf_we <= 1'b0;
						if (last_byte) begin
							start_wr <= 1'b1;
							state    <= ST_FLUSH;
						end else begin
							byte_addr <= byte_addr + 1'b1;
							drq       <= 1'b1;
							state     <= ST_XFER;
						end
					end
				ST_XFER:
					if (is_write && wr_data_ev) begin
						buf_we <= 1'b1; // byte goes in from data_reg
						drq    <= 1'b0;
						state  <= ST_XFER_WAIT;
					end else if (!is_write && rd_data_ev) begin
						drq <= 1'b0;
						if (!last_byte) begin
							byte_addr <= byte_addr + 1'b1;
							state     <= ST_XFER_WAIT;
						end else if (multi) begin
							sector_reg <= sector_reg + 1'b1;
							state      <= ST_SEARCH;
						end else begin
							state <= ST_END;
						end
					end
				ST_FLUSH:
					if (block_done) begin
						if (multi) begin
							sector_reg <= sector_reg + 1'b1;
							state      <= ST_SEARCH; // ends with record not found past the track
						end else begin
							state <= ST_END;
						end
					end
				ST_END: begin
					busy   <= 1'b0;
					drq    <= 1'b0;
					buf_we <= 1'b0;
					intrq  <= 1'b1;
					state  <= ST_IDLE;
				end
				default: ;
			endcase

			// ==============================
			// host register access
			// ==============================
			if (host_event.rd_done && host_event.addr == A_STATUS)
				intrq <= 1'b0; // status read acknowledges

			if (host_event.wr_pulse && host_event.addr == A_TRACK && !busy)
				track_reg <= host_event.data;
			if (host_event.wr_pulse && host_event.addr == A_SECTOR && !busy)
				sector_reg <= host_event.data;

			if (cmd_ev && op == CMD_FORCE_INT) begin
				state     <= ST_IDLE; // any state
				busy      <= 1'b0;
				drq       <= 1'b0;
				buf_we    <= 1'b0;
				intrq     <= 1'b1;
				type2     <= 1'b0;
				not_found <= 1'b0;
				wr_fault  <= 1'b0;
			end else if (cmd_ev && state == ST_IDLE) begin
				intrq <= 1'b0;
				case (op)
					CMD_RESTORE, CMD_SEEK, CMD_STEP, CMD_STEP | 4'h1, CMD_STEP_IN,
					CMD_STEP_IN | 4'h1, CMD_STEP_OUT, CMD_STEP_OUT | 4'h1: begin
						busy        <= 1'b1;
						type2       <= 1'b0;
						is_write    <= 1'b0;
						not_found   <= 1'b0;
						head_loaded <= host_event.data[3];
						settle_cnt  <= CW'(SETTLE_CYCLES);
						state       <= ST_SETTLE;
						if (op == CMD_RESTORE) begin
							head      <= '0;
							track_reg <= '0;
						end else if (op == CMD_SEEK) begin
							head      <= data_reg; // target track in data register
							track_reg <= data_reg;
						end else begin
							if (host_event.data[6])
								step_dir <= host_event.data[5];
							head <= next_head;
							if (host_event.data[4])
								track_reg <= next_head; // update flag
						end
					end
					CMD_READ, CMD_READ | 4'h1, CMD_WRITE, CMD_WRITE | 4'h1: begin
						busy      <= 1'b1;
						type2     <= 1'b1;
						is_write  <= op[1];
						multi     <= op[0];
						not_found <= 1'b0;
						wr_fault  <= 1'b0;
						if (op[1] && wp) begin
							wr_fault <= 1'b1; // protected disk, no transfer
							state    <= ST_END;
						end else begin
							settle_cnt <= CW'(SETTLE_CYCLES);
							state      <= ST_SETTLE;
						end
					end
					default: intrq <= 1'b1; // read address, read/write track
				endcase
			end
		end
	end

endmodule

//--- source/fdc_storage_link.sv
// one outstanding block request at a time; waits as long as needed for sd_ack
`timescale 1ns/10ps

module fdc_storage_link #(
	parameter int SECTORS_PER_TRACK = 9
) (
	input  logic                clk_sys,
	input  logic                reset_spin,
	input  fdc_pkg::block_req_t req,
	input  logic                sd_ack,
	output logic                sd_rd,
	output logic                sd_wr,
	output fdc_pkg::lba_t       sd_lba,
	output logic                block_done
);
	import fdc_pkg::*;

	logic ack_q;
	logic active; // request raised and block not yet finished
	lba_t lba;

	// (track * 2 + side) * spt + sector - 1
	assign lba = lba_t'({req.track, req.side}) * lba_t'(SECTORS_PER_TRACK)
			+ lba_t'(req.sector) - lba_t'(1);

	always_ff @(posedge clk_sys) begin
		if (req.start_read || req.start_write)
			sd_lba <= lba;

		if (reset_spin) begin
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			ack_q      <= 1'b0;
			active     <= 1'b0;
			block_done <= 1'b0;
		end else begin
			ack_q      <= sd_ack;
			block_done <= 1'b0;
			if (req.start_read || req.start_write) begin
				sd_rd  <= req.start_read;
				sd_wr  <= req.start_write;
				active <= 1'b1;
			end else if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0; // storage has taken the request
				sd_wr <= 1'b0;
			end
			if (active && ack_q && !sd_ack) begin
				active     <= 1'b0;
				block_done <= 1'b1; // falling ack ends the block
			end
		end
	end

endmodule

//--- source/fdc_sector_buffer.sv
// 512 x 8 true dual-port ram, one cycle read latency, a write returns the new data
`timescale 1ns/10ps

module fdc_sector_buffer (
	input  logic               clk_sys,
	input  fdc_pkg::buf_addr_t a_addr,
	input  fdc_pkg::byte_t     a_wdata,
	input  logic               a_we,
	output fdc_pkg::byte_t     a_rdata,
	input  fdc_pkg::buf_port_t b,
	output fdc_pkg::byte_t     b_rdata
);
	import fdc_pkg::*;

	byte_t mem [0:SECTOR_BYTES-1];

	always_ff @(posedge clk_sys) begin // storage side
		if (a_we) begin
			mem[a_addr] <= a_wdata;
			a_rdata     <= a_wdata;
		end else begin
			a_rdata <= mem[a_addr];
		end
	end

	always_ff @(posedge clk_sys) begin // engine side
		if (b.we) begin
			mem[b.addr] <= b.wdata;
			b_rdata     <= b.wdata;
		end else begin
			b_rdata <= mem[b.addr];
		end
	end

endmodule

//--- source/fdc_index_gen.sv
// index pulse only while ready; INDEX_PERIOD should be well above 32 cycles
`timescale 1ns/10ps

module fdc_index_gen #(
	parameter int INDEX_PERIOD = 4096
) (
	input  logic clk_sys,
	input  logic reset_spin,
	input  logic ready,
	output logic index
);
	localparam int CW = $clog2(INDEX_PERIOD);

	logic [CW-1:0] cnt; // position within one revolution

	always_ff @(posedge clk_sys) begin
		if (reset_spin || !ready)
			cnt <= '0;
		else if (cnt == CW'(INDEX_PERIOD - 1))
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign index = ready && (cnt < CW'(32)); // hole passes the sensor

endmodule

//--- source/fdc_top.sv
// fdc register core top; raw image only, 512-byte sectors, no lost-data timeout
`timescale 1ns/10ps

module fdc_top #(
	parameter int SECTORS_PER_TRACK = 9,
	parameter int SETTLE_CYCLES     = 64,
	parameter int INDEX_PERIOD      = 4096
) (
	input  logic               clk_sys,
	input  logic               reset_spin,
	// host bus
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::reg_addr_t addr,
	input  fdc_pkg::byte_t     din,
	output fdc_pkg::byte_t     dout,
	output logic               drq,
	output logic               intrq,
	output logic               busy,
	// drive
	input  logic               wp,
	input  logic               ready,
	input  logic               side,
	// block storage
	output logic               sd_rd,
	output logic               sd_wr,
	output fdc_pkg::lba_t      sd_lba,
	input  logic               sd_ack,
	input  fdc_pkg::buf_addr_t sd_buff_addr,
	input  fdc_pkg::byte_t     sd_buff_dout,
	output fdc_pkg::byte_t     sd_buff_din,
	input  logic               sd_buff_wr
);
	import fdc_pkg::*;

	host_event_t host_ev;
	block_req_t  blk_req;
	buf_port_t   buf_b;
	byte_t       buf_rdata;
	logic        index;
	logic        block_done;

	fdc_host_port host_i (
		.clk_sys    (clk_sys),
		.reset_spin (reset_spin),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.host_event (host_ev)
	);

	fdc_command_engine #(
		.SECTORS_PER_TRACK (SECTORS_PER_TRACK),
		.SETTLE_CYCLES     (SETTLE_CYCLES)
	) engine_i (
		.clk_sys    (clk_sys),
		.reset_spin (reset_spin),
		.host_event (host_ev),
		.addr       (addr),
		.ready      (ready),
		.wp         (wp),
		.side       (side),
		.index      (index),
		.block_done (block_done),
		.buf_rdata  (buf_rdata),
		.dout       (dout),
		.drq        (drq),
		.busy       (busy),
		.intrq      (intrq),
		.req        (blk_req),
		.buf_port   (buf_b)
	);

	fdc_index_gen #(
		.INDEX_PERIOD (INDEX_PERIOD)
	) index_i (
		.clk_sys    (clk_sys),
		.reset_spin (reset_spin),
		.ready      (ready),
		.index      (index)
	);

	fdc_storage_link #(
		.SECTORS_PER_TRACK (SECTORS_PER_TRACK)
	) link_i (
		.clk_sys    (clk_sys),
		.reset_spin (reset_spin),
		.req        (blk_req),
		.sd_ack     (sd_ack),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_lba     (sd_lba),
		.block_done (block_done)
	);

	fdc_sector_buffer buffer_i (
		.clk_sys (clk_sys),
		.a_addr  (sd_buff_addr),
		.a_wdata (sd_buff_dout),
		.a_we    (sd_buff_wr & sd_ack), // storage side writes only inside a block
		.a_rdata (sd_buff_din),
		.b       (buf_b),
		.b_rdata (buf_rdata)
	);

endmodule

//--- testbench/fdc_tb_disk_model.sv
// storage-side model; serves one whole block per request, block numbers must stay below NUM_BLOCKS
`timescale 1ns/10ps

module fdc_tb_disk_model #(
	parameter int NUM_BLOCKS = 720
) (
	input  logic               clk_sys,
	input  logic               sd_rd,
	input  logic               sd_wr,
	input  fdc_pkg::lba_t      sd_lba,
	output logic               sd_ack,
	output fdc_pkg::buf_addr_t sd_buff_addr,
	output fdc_pkg::byte_t     sd_buff_dout,
	input  fdc_pkg::byte_t     sd_buff_din,
	output logic               sd_buff_wr
);
	import fdc_pkg::*;

	byte_t image [0:NUM_BLOCKS*SECTOR_BYTES-1]; // raw disk image, block after block
	int    read_count;
	int    write_count;
	int    bad_lba_count;
	lba_t  last_lba;

	initial begin
		int i;

		sd_ack        = 1'b0;
		sd_buff_addr  = '0;
		sd_buff_dout  = '0;
		sd_buff_wr    = 1'b0;
		read_count    = 0;
		write_count   = 0;
		bad_lba_count = 0;
		last_lba      = '0;
		for (i = 0; i < NUM_BLOCKS * SECTOR_BYTES; i++)
			image[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16)); // whole address folded in
	end

	task automatic serve_block();
		int   i;
		int   base;
		logic is_read;

		is_read  = sd_rd;
		last_lba = sd_lba;
		base     = int'(sd_lba) * SECTOR_BYTES;
		sd_ack   = 1'b1;
		if (sd_lba >= lba_t'(NUM_BLOCKS)) begin
			bad_lba_count++; // outside the image, ack with no data
			@(negedge clk_sys);
		end else if (is_read) begin
			read_count++;
			for (i = 0; i < SECTOR_BYTES; i++) begin
				sd_buff_addr = buf_addr_t'(i);
				sd_buff_dout = image[base + i];
				sd_buff_wr   = 1'b1;
				@(negedge clk_sys);
			end
			sd_buff_wr = 1'b0;
		end else begin
			write_count++;
			sd_buff_addr = '0;
			for (i = 0; i < SECTOR_BYTES; i++) begin
				@(negedge clk_sys);
				image[base + i] = sd_buff_din; // one cycle behind the address
				sd_buff_addr    = buf_addr_t'(i + 1);
			end
		end
		sd_ack = 1'b0; // falling ack ends the block
		@(negedge clk_sys);
	endtask

	always begin
		@(negedge clk_sys);
		if (sd_rd || sd_wr)
			serve_block();
	end

endmodule

//--- testbench/fdc_tb.sv
// fdc_top testbench; fixed seed, 9 sectors per track, image covers the first 40 tracks only
`timescale 1ns/10ps

module fdc_tb;
	import fdc_pkg::*;

	localparam int SPT        = 9;
	localparam int NUM_TRACKS = 40;
	localparam int WAIT_LIMIT = 20000; // cycles allowed per wait
	localparam int W_INTRQ    = 0;
	localparam int W_DRQ      = 1;

	logic      clk_sys;
	logic      reset_spin;
	logic      rd, wr;
	reg_addr_t addr;
	byte_t     din, dout;
	logic      drq, intrq, busy;
	logic      wp, ready, side;
	logic      sd_rd, sd_wr, sd_ack, sd_buff_wr;
	lba_t      sd_lba;
	buf_addr_t sd_buff_addr;
	byte_t     sd_buff_dout, sd_buff_din;

	int    errors, checks, tests_run, test_errors;
	byte_t expect_q [$]; // bytes the host should read back

	fdc_top #(
		.SECTORS_PER_TRACK (SPT),
		.SETTLE_CYCLES     (16),
		.INDEX_PERIOD      (256)
	) dut_i (
		.clk_sys      (clk_sys),
		.reset_spin   (reset_spin),
		.rd           (rd),
		.wr           (wr),
		.addr         (addr),
		.din          (din),
		.dout         (dout),
		.drq          (drq),
		.intrq        (intrq),
		.busy         (busy),
		.wp           (wp),
		.ready        (ready),
		.side         (side),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din),
		.sd_buff_wr   (sd_buff_wr)
	);

	fdc_tb_disk_model #(
		.NUM_BLOCKS (NUM_TRACKS * 2 * SPT)
	) disk_i (
		.clk_sys      (clk_sys),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din),
		.sd_buff_wr   (sd_buff_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==============================
	// helpers
	// ==============================
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic abort_run(input string why);
		$display("run stopped: %s at %0t", why, $time);
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors + 1);
		$display("test failed");
		$finish;
	endtask

	task automatic wait_signal(input int sel, input logic level, input string what);
		int   n;
		logic val;

		for (n = 0; n < WAIT_LIMIT; n++) begin
			val = (sel == W_INTRQ) ? intrq : drq;
			if (val === level)
				return;
			@(negedge clk_sys);
		end
		abort_run({"timeout waiting for ", what});
	endtask

	task automatic host_write(input reg_addr_t a, input byte_t d);
		@(negedge clk_sys);
		addr = a;
		din  = d;
		wr   = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
		@(negedge clk_sys); // engine has taken the event
	endtask

	task automatic host_read(input reg_addr_t a, output byte_t d);
		@(negedge clk_sys);
		addr = a;
		rd   = 1'b1;
		@(negedge clk_sys);
		d  = dout;
		rd = 1'b0;
		repeat (2) @(negedge clk_sys); // rd_done reaches the engine
	endtask

	task automatic seek_to(input int t);
		byte_t d;

		host_write(A_DATA, byte_t'(t));
		host_write(A_COMMAND, {CMD_SEEK, 4'h0});
		wait_signal(W_INTRQ, 1'b1, "seek intrq");
		host_read(A_STATUS, d);
	endtask

	// (track * 2 + side) * spt + sector - 1
	function automatic int block_of(input int t, input int s, input int sec);
		return (t * 2 + s) * SPT + sec - 1;
	endfunction

	task automatic preload_block(input int lba);
		int    i;
		byte_t b;

		for (i = 0; i < SECTOR_BYTES; i++) begin
			b = byte_t'($urandom);
			disk_i.image[lba * SECTOR_BYTES + i] = b;
			expect_q.push_back(b);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("%-18s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILING", test_errors);
		test_errors = 0;
	endtask

	// ==============================
	// tests
	// ==============================
	initial begin
		int     i, k, t, s, sec, sec0, kind, lba, rd_before, wr_before, count;
		byte_t  d, cmd;
		track_t head_m, track_m;
		logic   dir_m, upd;
		byte_t  wbytes [0:SECTOR_BYTES-1];

		void'($urandom(32'h02bddd34));
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		test_errors = 0;
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = '0;
		din         = '0;
		wp          = 1'b0;
		ready       = 1'b1;
		side        = 1'b0;
		reset_spin  = 1'b1;
		repeat (5) @(negedge clk_sys);
		reset_spin = 1'b0;
		@(negedge clk_sys);

		// reset values, then seeks
		check_value("busy", busy, 0);
		check_value("drq", drq, 0);
		check_value("intrq", intrq, 0);
		check_value("sd_rd", sd_rd, 0);
		check_value("sd_wr", sd_wr, 0);
		host_read(A_TRACK, d);
		check_value("track", d, 0);
		host_read(A_SECTOR, d);
		check_value("sector", d, 0);
		for (k = 0; k < 6; k++) begin
			t = (k == 1) ? 0 : 1 + $urandom % (NUM_TRACKS - 1);
			host_write(A_DATA, byte_t'(t));
			host_write(A_COMMAND, {CMD_SEEK, 4'h0});
			check_value("busy", busy, 1);
			wait_signal(W_INTRQ, 1'b1, "seek intrq");
			check_value("busy", busy, 0);
			host_read(A_STATUS, d);
			check_value("status_track0", d[2], t == 0);
			host_read(A_TRACK, d);
			check_value("track", d, t);
		end
		finish_test("reset and seek");

		// stepping against a model head
		host_write(A_COMMAND, {CMD_RESTORE, 4'h0});
		wait_signal(W_INTRQ, 1'b1, "restore intrq");
		host_read(A_STATUS, d);
		check_value("status_track0", d[2], 1);
		head_m  = '0;
		track_m = '0;
		dir_m   = 1'b0;
		for (k = 0; k < 24; k++) begin
			kind = (k == 0) ? 1 : $urandom % 3; // first one sets the direction
			upd  = $urandom % 2;
			case (kind)
				0:       cmd = {CMD_STEP, 4'h0};
				1:       cmd = {CMD_STEP_IN, 4'h0};
				default: cmd = {CMD_STEP_OUT, 4'h0};
			endcase
			cmd[4] = upd;
			if (kind == 1)
				dir_m = 1'b0;
			else if (kind == 2)
				dir_m = 1'b1;
			if (dir_m)
				head_m = (head_m == 0) ? head_m : head_m - 1'b1; // stops at track 0
			else
				head_m = head_m + 1'b1;
			if (upd)
				track_m = head_m;
			host_write(A_COMMAND, cmd);
			wait_signal(W_INTRQ, 1'b1, "step intrq");
			host_read(A_STATUS, d);
			check_value("status_track0", d[2], head_m == 0);
			host_read(A_TRACK, d);
			check_value("track", d, track_m);
		end
		finish_test("stepping");

		// single sector write
		t    = $urandom % NUM_TRACKS;
		s    = $urandom % 2;
		sec  = 1 + $urandom % SPT;
		lba  = block_of(t, s, sec);
		side = s[0];
		seek_to(t);
		for (i = 0; i < SECTOR_BYTES; i++)
			wbytes[i] = byte_t'($urandom);
		wr_before = disk_i.write_count;
		host_write(A_SECTOR, byte_t'(sec));
		host_write(A_COMMAND, {CMD_WRITE, 4'h0});
		for (i = 0; i < SECTOR_BYTES; i++) begin
			wait_signal(W_DRQ, 1'b1, "write drq");
			host_write(A_DATA, wbytes[i]);
		end
		wait_signal(W_INTRQ, 1'b1, "write intrq");
		host_read(A_STATUS, d);
		check_value("status", d & 8'hF1, 0);
		check_value("write_count", disk_i.write_count - wr_before, 1);
		check_value("sd_lba", disk_i.last_lba, lba);
		for (i = 0; i < SECTOR_BYTES; i++)
			check_value("image", disk_i.image[lba * SECTOR_BYTES + i], wbytes[i]);
		finish_test("write sector");

		// multi-sector read up to the end of the track
		t    = $urandom % NUM_TRACKS;
		s    = $urandom % 2;
		sec0 = SPT - $urandom % 3;
		side = s[0];
		expect_q.delete();
		for (sec = sec0; sec <= SPT; sec++)
			preload_block(block_of(t, s, sec));
		seek_to(t);
		rd_before = disk_i.read_count;
		host_write(A_SECTOR, byte_t'(sec0));
		host_write(A_COMMAND, {CMD_READ | 4'h1, 4'h0});
		for (i = 0; i < expect_q.size(); i++) begin
			wait_signal(W_DRQ, 1'b1, "read drq");
			host_read(A_DATA, d);
			check_value("dout", d, expect_q[i]);
		end
		wait_signal(W_INTRQ, 1'b1, "multi read intrq");
		host_read(A_SECTOR, d);
		check_value("sector", d, SPT + 1);
		host_read(A_STATUS, d);
		check_value("status_rnf", d[4], 1); // ran off the track
		check_value("read_count", disk_i.read_count - rd_before, SPT - sec0 + 1);
		check_value("sd_lba", disk_i.last_lba, block_of(t, s, SPT));
		finish_test("multi-sector read");

		// record not found and write protect
		rd_before = disk_i.read_count;
		wr_before = disk_i.write_count;
		for (k = 0; k < 2; k++) begin
			sec = (k == 0) ? 0 : SPT + 1 + $urandom % 20;
			host_write(A_SECTOR, byte_t'(sec));
			host_write(A_COMMAND, {CMD_READ, 4'h0});
			wait_signal(W_INTRQ, 1'b1, "bad sector intrq");
			host_read(A_STATUS, d);
			check_value("status_rnf", d[4], 1);
		end
		check_value("read_count", disk_i.read_count - rd_before, 0);
		wp = 1'b1;
		host_write(A_SECTOR, 8'd1);
		host_write(A_COMMAND, {CMD_WRITE, 4'h0});
		wait_signal(W_INTRQ, 1'b1, "protected write intrq");
		host_read(A_STATUS, d);
		check_value("status_wp_fault", d[6:5], 2'b11);
		check_value("write_count", disk_i.write_count - wr_before, 0);
		check_value("sd_wr", sd_wr, 0);
		wp = 1'b0;
		finish_test("errors");

		// force interrupt in the middle of a read
		t    = $urandom % NUM_TRACKS;
		s    = $urandom % 2;
		sec  = 1 + $urandom % SPT;
		side = s[0];
		expect_q.delete();
		preload_block(block_of(t, s, sec));
		seek_to(t);
		host_write(A_SECTOR, byte_t'(sec));
		host_write(A_COMMAND, {CMD_READ, 4'h0});
		count = 5 + $urandom % 200;
		for (i = 0; i < count; i++) begin
			wait_signal(W_DRQ, 1'b1, "read drq");
			host_read(A_DATA, d);
			check_value("dout", d, expect_q[i]);
		end
		wait_signal(W_DRQ, 1'b1, "drq before interrupt");
		host_write(A_COMMAND, {CMD_FORCE_INT, 4'h0});
		check_value("busy", busy, 0);
		check_value("drq", drq, 0);
		check_value("intrq", intrq, 1);
		host_read(A_STATUS, d);
		check_value("status_busy", d[0], 0);
		finish_test("force interrupt");

		check_value("bad_lba_count", disk_i.bad_lba_count, 0);
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- fdc_top.f
source/fdc_pkg.sv
source/fdc_host_port.sv
source/fdc_command_engine.sv
source/fdc_storage_link.sv
source/fdc_sector_buffer.sv
source/fdc_index_gen.sv
source/fdc_top.sv
testbench/fdc_tb_disk_model.sv
testbench/fdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with verilator; exit status is 0 only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fdc_tb -f fdc_top.f -o fdc_sim \
	&& ./obj_dir/fdc_sim > sim.log \
	&& cat sim.log \
	&& grep -qx "test passed" sim.log \
	|| { cat sim.log 2>/dev/null; echo "simulation did not pass"; exit 1; }
